//--- design/rv_core_params.svh
/*
  Architectural constants for the RV32I datapath.
  Include wherever widths or opcode values are needed; guarded
  so that several files in one compile unit may include it.
*/

`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Data width and register count
`define RV_XLEN  32
`define RV_NREGS 32

// Major opcodes kept by this core
`define RV_OP_REG  7'b0110011
`define RV_OP_IMM  7'b0010011
`define RV_OP_LUI  7'b0110111
`define RV_OP_JAL  7'b1101111
`define RV_OP_JALR 7'b1100111

`endif

//--- design/rv_core_pkg.sv
/*
  Shared types for the three-stage RV32I datapath.
  Holds the instruction union, the ALU op encoding and the
  records carried between decode, execute and writeback.
*/

`include "rv_core_params.svh"

package rv_core_pkg;

  //////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  // Register-immediate layout
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // Same 32 bits, read either way
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  // ALU operations, pass-B serves lui
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
  } alu_op_e;

  //////////////////////////////////////////////////
  // Stage records
  //////////////////////////////////////////////////

  // Decode to execute
  typedef struct packed {
    logic               valid;
    logic [`RV_XLEN-1:0] pc;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [4:0]         rd;
    logic [`RV_XLEN-1:0] imm;
    alu_op_e            alu_op;
    logic               use_imm;   // B operand is the immediate
    logic               rs1_used;
    logic               link;      // result is pc+4
    logic               we;
  } decode_t;

  // Execute to writeback
  typedef struct packed {
    logic               valid;
    logic [4:0]         rd;
    logic               we;
    logic               link;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] pc_plus4;
  } exec_t;

  // Writeback result, also the forwarding bundle
  typedef struct packed {
    logic               valid;
    logic [4:0]         rd;
    logic [`RV_XLEN-1:0] data;
  } wb_t;

endpackage

//--- design/rv_decode.sv
/*
  Decode stage of the RV32I datapath.
  Splits the incoming word, builds immediates and the ALU op,
  and registers the decoded record for execute. Holds on stall.
*/

`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_decode (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  stall_i,
  input  logic                  flush_i,
  input  logic                  instr_valid_i,
  input  rv_core_pkg::instr_u   instr_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  output rv_core_pkg::decode_t  dec_o
);

  rv_core_pkg::decode_t dec_d;
  rv_core_pkg::decode_t dec_q;
  logic [`RV_XLEN-1:0]  imm_i_ext;
  logic [`RV_XLEN-1:0]  imm_u_ext;
  logic                 sh_alt;

  // funct3 mapping shared by OP and OP-IMM
  function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    rv_core_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  op = rv_core_pkg::ALU_SLL;
      3'b010:  op = rv_core_pkg::ALU_SLT;
      3'b011:  op = rv_core_pkg::ALU_SLTU;
      3'b100:  op = rv_core_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  op = rv_core_pkg::ALU_OR;
      default: op = rv_core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  // Sign-extended I immediate, U immediate from the upper 20 bits
  assign imm_i_ext = {{(`RV_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
  assign imm_u_ext = {instr_i.i.imm12, instr_i.i.rs1, instr_i.i.funct3, 12'b0};

  // Only srai looks at bit 30 in the I form
  assign sh_alt = (instr_i.i.funct3 == 3'b101) && instr_i.r.funct7[5];

  always_comb begin
    dec_d        = '0;
    dec_d.valid  = instr_valid_i;
    dec_d.pc     = pc_i;
    dec_d.rs1    = instr_i.r.rs1;
    dec_d.rs2    = instr_i.r.rs2;
    dec_d.rd     = instr_i.r.rd;
    dec_d.alu_op = rv_core_pkg::ALU_ADD;
    case (instr_i.r.opcode)
      `RV_OP_REG: begin
        dec_d.alu_op   = alu_sel(instr_i.r.funct3, instr_i.r.funct7[5]);
        dec_d.rs1_used = 1'b1;
        dec_d.we       = 1'b1;
      end
      `RV_OP_IMM: begin
        dec_d.alu_op   = alu_sel(instr_i.i.funct3, sh_alt);
        dec_d.imm      = imm_i_ext;
        dec_d.use_imm  = 1'b1;
        dec_d.rs1_used = 1'b1;
        dec_d.we       = 1'b1;
      end
      `RV_OP_LUI: begin
        dec_d.alu_op  = rv_core_pkg::ALU_PASS_B;
        dec_d.imm     = imm_u_ext;
        dec_d.use_imm = 1'b1;
        dec_d.we      = 1'b1;
      end
      // Links only, the ALU value is not used
      `RV_OP_JAL: begin
        dec_d.link = 1'b1;
        dec_d.we   = 1'b1;
      end
      `RV_OP_JALR: begin
        dec_d.imm      = imm_i_ext;
        dec_d.use_imm  = 1'b1;
        dec_d.rs1_used = 1'b1;
        dec_d.link     = 1'b1;
        dec_d.we       = 1'b1;
      end
      // Unknown opcode passes through with no write
      default: dec_d.we = 1'b0;
    endcase
    // x0 is never a destination
    if (dec_d.rd == 5'd0) begin
      dec_d.we = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dec_q <= '0;
    end else if (flush_i) begin
      dec_q.valid <= 1'b0;
    end else if (!stall_i) begin
      dec_q <= dec_d;
    end
  end

  assign dec_o = dec_q;

endmodule

//--- design/rv_regfile.sv
/*
  Integer register file, 32 entries of 32 bits.
  Two combinational read ports and one synchronous write port;
  x0 always reads zero.
*/

`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_regfile (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [4:0]          rs1_addr_i,
  input  logic [4:0]          rs2_addr_i,
  output logic [`RV_XLEN-1:0] rs1_data_o,
  output logic [`RV_XLEN-1:0] rs2_data_o,
  input  logic                wr_en_i,
  input  logic [4:0]          wr_addr_i,
  input  logic [`RV_XLEN-1:0] wr_data_i
);

  logic [`RV_XLEN-1:0] regs_q [`RV_NREGS];

  // Write port, x0 writes dropped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != 5'd0)) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Read ports
  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs_q[rs2_addr_i];

endmodule

//--- design/rv_execute.sv
/*
  Execute stage of the RV32I datapath.
  Reads operands with forwarding from writeback, runs the ALU,
  forms pc+4 and registers the result record.
*/

`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_execute (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 stall_i,
  input  logic                 flush_i,
  input  rv_core_pkg::decode_t dec_i,
  output logic [4:0]           rs1_addr_o,
  output logic [4:0]           rs2_addr_o,
  input  logic [`RV_XLEN-1:0]  rs1_data_i,
  input  logic [`RV_XLEN-1:0]  rs2_data_i,
  input  rv_core_pkg::wb_t     fwd_i,
  output rv_core_pkg::exec_t   exe_o
);

  logic [`RV_XLEN-1:0] rs1_val, rs2_val;
  logic [`RV_XLEN-1:0] op_a, op_b;
  logic [`RV_XLEN-1:0] alu_res;
  logic [4:0]          shamt;
  logic                fwd_ok;
  rv_core_pkg::exec_t  exe_q;

  assign rs1_addr_o = dec_i.rs1;
  assign rs2_addr_o = dec_i.rs2;

  // Writeback value beats the stale register file read
  assign fwd_ok  = fwd_i.valid && (fwd_i.rd != 5'd0);
  assign rs1_val = (fwd_ok && fwd_i.rd == dec_i.rs1) ? fwd_i.data : rs1_data_i;
  assign rs2_val = (fwd_ok && fwd_i.rd == dec_i.rs2) ? fwd_i.data : rs2_data_i;

  assign op_a  = dec_i.rs1_used ? rs1_val : '0;
  assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_val;
  assign shamt = op_b[4:0];

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////
  always_comb begin
    case (dec_i.alu_op)
      rv_core_pkg::ALU_ADD:  alu_res = op_a + op_b;
      rv_core_pkg::ALU_SUB:  alu_res = op_a - op_b;
      rv_core_pkg::ALU_AND:  alu_res = op_a & op_b;
      rv_core_pkg::ALU_OR:   alu_res = op_a | op_b;
      rv_core_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      rv_core_pkg::ALU_SLL:  alu_res = op_a << shamt;
      rv_core_pkg::ALU_SRL:  alu_res = op_a >> shamt;
      rv_core_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
      rv_core_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_core_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
      default:               alu_res = op_b;  // pass-B for lui
    endcase
  end

  // Result record, held during stall
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exe_q <= '0;
    end else if (flush_i) begin
      exe_q.valid <= 1'b0;
    end else if (!stall_i) begin
      exe_q.valid      <= dec_i.valid;
      exe_q.rd         <= dec_i.rd;
      exe_q.we         <= dec_i.we;
      exe_q.link       <= dec_i.link;
      exe_q.alu_result <= alu_res;
      exe_q.pc_plus4   <= dec_i.pc + `RV_XLEN'd4;
    end
  end

  assign exe_o = exe_q;

endmodule

//--- design/rv_writeback.sv
/*
  Writeback stage of the RV32I datapath, purely combinational.
  Picks the link address or the ALU value and gates the register
  file write with stall and flush; also drives the result port.
*/

`timescale 1ns/1ps

module rv_writeback (
  input  logic               stall_i,
  input  logic               flush_i,
  input  rv_core_pkg::exec_t exe_i,
  output logic               rf_wr_en_o,
  output logic [4:0]         rf_wr_addr_o,
  output logic [31:0]        rf_wr_data_o,
  output rv_core_pkg::wb_t   wb_o
);

  logic        wr_en;
  logic [31:0] wr_data;

  // Any stall level or a flush pulse kills the write
  assign wr_en   = exe_i.valid && exe_i.we && !stall_i && !flush_i;

  // Link value for jal/jalr, ALU otherwise
  assign wr_data = exe_i.link ? exe_i.pc_plus4 : exe_i.alu_result;

  assign rf_wr_en_o   = wr_en;
  assign rf_wr_addr_o = exe_i.rd;
  assign rf_wr_data_o = wr_data;

  // Result port mirrors the write, quiet otherwise
  always_comb begin
    wb_o.valid = wr_en;
    wb_o.rd    = wr_en ? exe_i.rd : 5'd0;
    wb_o.data  = wr_en ? wr_data : 32'd0;
  end

endmodule

//--- design/rv_core_top.sv
/*
  Top level of the three-stage RV32I datapath.
  Instruction and pc enter on a valid strobe; one result per
  cycle leaves on wb_o two cycles later. Stall holds, flush kills.
*/

`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_core_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                instr_valid_i,
  input  rv_core_pkg::instr_u instr_i,
  input  logic [`RV_XLEN-1:0] pc_i,
  input  logic                stall_i,
  input  logic                flush_i,
  output rv_core_pkg::wb_t    wb_o
);

  rv_core_pkg::decode_t dec_q;
  rv_core_pkg::exec_t   exe_q;
  rv_core_pkg::wb_t     wb_s;
  logic [4:0]           rs1_addr, rs2_addr;
  logic [`RV_XLEN-1:0]  rs1_data, rs2_data;
  logic                 rf_wr_en;
  logic [4:0]           rf_wr_addr;
  logic [`RV_XLEN-1:0]  rf_wr_data;

  //////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////
  rv_decode u_decode (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .pc_i         (pc_i),
    .dec_o        (dec_q)
  );

  // Forwarding comes straight from the writeback result
  rv_execute u_execute (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .stall_i   (stall_i),
    .flush_i   (flush_i),
    .dec_i     (dec_q),
    .rs1_addr_o(rs1_addr),
    .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .fwd_i     (wb_s),
    .exe_o     (exe_q)
  );

  rv_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rs1_addr_i(rs1_addr),
    .rs2_addr_i(rs2_addr),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data),
    .wr_en_i   (rf_wr_en),
    .wr_addr_i (rf_wr_addr),
    .wr_data_i (rf_wr_data)
  );

  rv_writeback u_writeback (
    .stall_i     (stall_i),
    .flush_i     (flush_i),
    .exe_i       (exe_q),
    .rf_wr_en_o  (rf_wr_en),
    .rf_wr_addr_o(rf_wr_addr),
    .rf_wr_data_o(rf_wr_data),
    .wb_o        (wb_s)
  );

  assign wb_o = wb_s;

endmodule

//--- test/rv_core_assert.sv
/*
  Concurrent checks on the writeback outputs of the datapath.
  Bound into every rv_core_top instance by the bind below.
*/

`timescale 1ns/1ps

module rv_core_assert (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             stall_i,
  input logic             flush_i,
  input rv_core_pkg::wb_t wb_i,
  input logic             wr_en_i,
  input logic [4:0]       wr_addr_i
);

  // No result while the pipe is held
  a_stall_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_i |-> !wb_i.valid)
    else $error("wb_o valid while stall_i is high");

  // Flush kills the write in its own cycle
  a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |-> !wb_i.valid)
    else $error("wb_o valid in a flush cycle");

  // First cycle out of reset
  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !wb_i.valid)
    else $error("wb_o valid right after reset release");

  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_en_i |-> (wr_addr_i != 5'd0))
    else $error("register file write to x0");

endmodule

bind rv_core_top rv_core_assert u_assert (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .stall_i  (stall_i),
  .flush_i  (flush_i),
  .wb_i     (wb_o),
  .wr_en_i  (rf_wr_en),
  .wr_addr_i(rf_wr_addr)
);

//--- test/rv_core_tb.sv
/*
  Testbench for the three-stage RV32I datapath.
  A directed table and an LFSR-built stream are applied one row per
  cycle; wb_o is checked against a two-slot model of the pipeline.
*/

`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_core_tb;

  localparam int          N_RANDOM = 200;
  localparam logic [31:0] PC_BASE  = 32'h0000_0100;

  // R-type funct3 and bit 30, indexed by op number
  localparam logic [2:0] R_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                       3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  localparam logic [9:0] R_ALT = 10'b0010000010;

  // One stimulus row with its expected result
  typedef struct {
    string               name;
    rv_core_pkg::instr_u instr;
    logic [31:0]         pc;
    logic                stall;
    logic                flush;
    rv_core_pkg::wb_t    exp;
  } row_t;

  logic                clk;
  logic                rst_n;
  logic                instr_valid;
  rv_core_pkg::instr_u instr;
  logic [31:0]         pc;
  logic                stall;
  logic                flush;
  rv_core_pkg::wb_t    wb;

  row_t        rows[$];
  int          inflight[$];   // [0] sits in execute reg, [1] in decode reg
  logic [31:0] ref_regs [32];
  logic [15:0] lfsr_state;
  logic        table_ready;

  rv_core_top dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .instr_valid_i(instr_valid),
    .instr_i      (instr),
    .pc_i         (pc),
    .stall_i      (stall),
    .flush_i      (flush),
    .wb_o         (wb)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Galois LFSR, 16 bits, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // Gathers n bits, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic rv_core_pkg::instr_u r_word(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
  endfunction

  function automatic rv_core_pkg::instr_u i_word(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_core_pkg::instr_u u_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `RV_OP_LUI};
  endfunction

  // jal, offset bits are don't-care here
  function automatic rv_core_pkg::instr_u j_word(input logic [4:0] rd);
    return {20'h0, rd, `RV_OP_JAL};
  endfunction

  function automatic rv_core_pkg::wb_t result(input logic [4:0] rd, input logic [31:0] data);
    return {1'b1, rd, data};
  endfunction

  // RV32I integer rules by funct3, alt is instruction bit 30
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
      input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] y;
    sh = b[4:0];
    case (f3)
      3'd0: y = alt ? a - b : a + b;
      3'd1: y = a << sh;
      // Signs differ, so a is less exactly when it is negative
      3'd2: y = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      3'd3: y = {31'b0, a < b};
      3'd4: y = a ^ b;
      3'd5: y = alt ? (a >> sh) | (~(32'hFFFF_FFFF >> sh) & {32{a[31]}}) : a >> sh;
      3'd6: y = a | b;
      default: y = a & b;
    endcase
    return y;
  endfunction

  function automatic logic [31:0] next_pc();
    return PC_BASE + 32'(rows.size()) * 32'd4;
  endfunction

  // Appends a row, valid results also land in the register model
  task automatic add_row(input string name, input rv_core_pkg::instr_u w,
      input logic st, input logic fl, input rv_core_pkg::wb_t exp);
    row_t r;
    r.name  = name;
    r.instr = w;
    r.pc    = next_pc();
    r.stall = st;
    r.flush = fl;
    r.exp   = exp;
    rows.push_back(r);
    if (exp.valid) begin
      ref_regs[exp.rd] = exp.data;
    end
  endtask

  // Links return pc+4, rd of x0 gives nothing
  task automatic link_row(input string name, input rv_core_pkg::instr_u w);
    rv_core_pkg::wb_t exp;
    exp = '0;
    if (w.r.rd != 5'd0) begin
      exp = result(w.r.rd, next_pc() + 32'd4);
    end
    add_row(name, w, 1'b0, 1'b0, exp);
  endtask

  task automatic load_directed();
    // Immediates straight after reset
    add_row("addi_x1", i_word(12'd5, 5'd0, 3'd0, 5'd1, `RV_OP_IMM), 1'b0, 1'b0,
            result(5'd1, 32'd5));
    add_row("addi_x2_neg", i_word(12'hFFD, 5'd0, 3'd0, 5'd2, `RV_OP_IMM), 1'b0, 1'b0,
            result(5'd2, 32'hFFFF_FFFD));
    add_row("lui_x3", u_word(20'h12345, 5'd3), 1'b0, 1'b0, result(5'd3, 32'h1234_5000));
    add_row("addi_x4_max", i_word(12'h7FF, 5'd0, 3'd0, 5'd4, `RV_OP_IMM), 1'b0, 1'b0,
            result(5'd4, 32'h0000_07FF));
    add_row("addi_x5_min", i_word(12'h800, 5'd0, 3'd0, 5'd5, `RV_OP_IMM), 1'b0, 1'b0,
            result(5'd5, 32'hFFFF_F800));
    // R-type with x1 = 5 and x2 = -3
    add_row("add", r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd6), 1'b0, 1'b0, result(5'd6, 32'd2));
    add_row("sub", r_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd7), 1'b0, 1'b0, result(5'd7, 32'd8));
    add_row("and", r_word(7'h00, 5'd2, 5'd1, 3'd7, 5'd8), 1'b0, 1'b0, result(5'd8, 32'd5));
    add_row("or", r_word(7'h00, 5'd2, 5'd1, 3'd6, 5'd9), 1'b0, 1'b0,
            result(5'd9, 32'hFFFF_FFFD));
    add_row("xor", r_word(7'h00, 5'd2, 5'd1, 3'd4, 5'd10), 1'b0, 1'b0,
            result(5'd10, 32'hFFFF_FFF8));
    add_row("sll", r_word(7'h00, 5'd1, 5'd2, 3'd1, 5'd11), 1'b0, 1'b0,
            result(5'd11, 32'hFFFF_FFA0));
    add_row("srl", r_word(7'h00, 5'd1, 5'd2, 3'd5, 5'd12), 1'b0, 1'b0,
            result(5'd12, 32'h07FF_FFFF));
    add_row("sra", r_word(7'h20, 5'd1, 5'd2, 3'd5, 5'd13), 1'b0, 1'b0,
            result(5'd13, 32'hFFFF_FFFF));
    add_row("slt", r_word(7'h00, 5'd1, 5'd2, 3'd2, 5'd14), 1'b0, 1'b0, result(5'd14, 32'd1));
    add_row("sltu", r_word(7'h00, 5'd1, 5'd2, 3'd3, 5'd15), 1'b0, 1'b0, result(5'd15, 32'd0));
    // Dependent chain, distance one and two
    add_row("chain_addi", i_word(12'd10, 5'd1, 3'd0, 5'd16, `RV_OP_IMM), 1'b0, 1'b0,
            result(5'd16, 32'd15));
    add_row("chain_add", r_word(7'h00, 5'd1, 5'd16, 3'd0, 5'd17), 1'b0, 1'b0,
            result(5'd17, 32'd20));
    add_row("chain_sub", r_word(7'h20, 5'd16, 5'd17, 3'd0, 5'd18), 1'b0, 1'b0,
            result(5'd18, 32'd5));
    add_row("chain_slli", i_word(12'd3, 5'd18, 3'd1, 5'd19, `RV_OP_IMM), 1'b0, 1'b0,
            result(5'd19, 32'd40));
    add_row("srai_neg", i_word(12'h401, 5'd2, 3'd5, 5'd20, `RV_OP_IMM), 1'b0, 1'b0,
            result(5'd20, 32'hFFFF_FFFE));
    add_row("chain_xori", i_word(12'hFFF, 5'd19, 3'd4, 5'd21, `RV_OP_IMM), 1'b0, 1'b0,
            result(5'd21, 32'hFFFF_FFD7));
    // Links, then x0 must still read zero
    link_row("jal_x22", j_word(5'd22));
    link_row("jalr_x23", i_word(12'd0, 5'd1, 3'd0, 5'd23, `RV_OP_JALR));
    link_row("jal_x0", j_word(5'd0));
    add_row("read_x0", r_word(7'h00, 5'd1, 5'd0, 3'd0, 5'd24), 1'b0, 1'b0, result(5'd24, 32'd5));
    // Three stall cycles hold the pipe
    add_row("pre_stall", i_word(12'd100, 5'd0, 3'd0, 5'd25, `RV_OP_IMM), 1'b0, 1'b0,
            result(5'd25, 32'd100));
    repeat (3) add_row("stall", '0, 1'b1, 1'b0, '0);
    add_row("post_stall", i_word(12'd1, 5'd25, 3'd0, 5'd26, `RV_OP_IMM), 1'b0, 1'b0,
            result(5'd26, 32'd101));
    // Both in-flight writes are killed by the flush
    add_row("killed_x25", i_word(12'd55, 5'd0, 3'd0, 5'd25, `RV_OP_IMM), 1'b0, 1'b0, '0);
    add_row("killed_x26", i_word(12'd66, 5'd0, 3'd0, 5'd26, `RV_OP_IMM), 1'b0, 1'b0, '0);
    add_row("flush", '0, 1'b0, 1'b1, '0);
    add_row("old_values", r_word(7'h00, 5'd26, 5'd25, 3'd0, 5'd27), 1'b0, 1'b0,
            result(5'd27, 32'd201));
  endtask

  // One LFSR entry, sometimes after one or two stall cycles
  task automatic random_entry(input int n);
    logic [3:0]          kind;
    logic [4:0]          rd, rs1, rs2;
    logic [2:0]          f3, st;
    logic                alt;
    logic [11:0]         imm;
    logic [19:0]         imm20;
    rv_core_pkg::instr_u w;
    string               name;
    st    = 3'(rand_bits(3));
    kind  = 4'(rand_bits(4));
    rd    = 5'(rand_bits(5));
    rs1   = 5'(rand_bits(5));
    rs2   = 5'(rand_bits(5));
    f3    = 3'(rand_bits(3));
    alt   = rand_bits(1) != 32'd0;
    imm   = 12'(rand_bits(12));
    imm20 = 20'(rand_bits(20));
    name  = $sformatf("rand%0d_k%0d", n, kind);
    if (st < 3'd2) begin
      repeat (int'(st) + 1) add_row("rand_stall", '0, 1'b1, 1'b0, '0);
    end
    if (kind < 4'd10) begin
      w = r_word({1'b0, R_ALT[kind], 5'b0}, rs2, rs1, R_F3[kind], rd);
      add_row(name, w, 1'b0, 1'b0, (rd == 5'd0) ? '0 :
              result(rd, ref_alu(R_F3[kind], R_ALT[kind], ref_regs[rs1], ref_regs[rs2])));
    end else if (kind == 4'd12) begin
      add_row(name, u_word(imm20, rd), 1'b0, 1'b0, (rd == 5'd0) ? '0 : result(rd, {imm20, 12'b0}));
    end else if (kind == 4'd13) begin
      link_row(name, j_word(rd));
    end else if (kind == 4'd14) begin
      link_row(name, i_word(imm, rs1, 3'd0, rd, `RV_OP_JALR));
    end else begin
      // Shift immediates keep only shamt and bit 30
      alt = alt && (f3 == 3'd5);
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {1'b0, alt, 5'b0, imm[4:0]};
      end
      w = i_word(imm, rs1, f3, rd, `RV_OP_IMM);
      add_row(name, w, 1'b0, 1'b0, (rd == 5'd0) ? '0 :
              result(rd, ref_alu(f3, alt, ref_regs[rs1], {{20{imm[11]}}, imm})));
    end
  endtask

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic end_failed();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_wb(input string name, input rv_core_pkg::wb_t exp,
      input rv_core_pkg::wb_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected valid=%0b rd=%0d data=%08h, actual valid=%0b rd=%0d data=%08h",
               name, exp.valid, exp.rd, exp.data, act.valid, act.rd, act.data);
      end_failed();
    end
  endtask

  // Quiet cycle, all fields zero
  task automatic check_idle(input string name, input rv_core_pkg::wb_t act);
    if (act !== '0) begin
      $display("FAIL %s: expected idle 0, actual valid=%0b rd=%0d data=%08h",
               name, act.valid, act.rd, act.data);
      end_failed();
    end
  endtask

  // Row i is on the inputs, inflight[0] is presenting
  task automatic score_cycle(input int i);
    int idx;
    idx = inflight[0];
    if (rows[i].stall || rows[i].flush) begin
      check_idle(rows[i].name, wb);
    end else if (idx < 0) begin
      check_idle("empty", wb);
    end else if (!rows[idx].exp.valid) begin
      check_idle(rows[idx].name, wb);
    end else begin
      check_wb(rows[idx].name, rows[idx].exp, wb);
    end
  endtask

  // Model of the next edge
  task automatic shift_pipe(input int i);
    if (rows[i].flush) begin
      inflight[0] = -1;
      inflight[1] = -1;
    end else if (!rows[i].stall) begin
      void'(inflight.pop_front());
      inflight.push_back(i);
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    stall       = 1'b0;
    flush       = 1'b0;
    table_ready = 1'b0;
    lfsr_state  = 16'd19056;
    for (int k = 0; k < 32; k++) begin
      ref_regs[k] = '0;
    end
    load_directed();
    for (int n = 0; n < N_RANDOM; n++) begin
      random_entry(n);
    end
    repeat (3) add_row("drain", '0, 1'b0, 1'b0, '0);
    inflight.push_back(-1);
    inflight.push_back(-1);
    table_ready = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      instr_valid <= (rows[i].instr != '0);
      instr       <= rows[i].instr;
      pc          <= rows[i].pc;
      stall       <= rows[i].stall;
      flush       <= rows[i].flush;
      @(negedge clk);
      score_cycle(i);
      shift_pipe(i);
    end
    $display("Finished with no errors");
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    int limit;
    wait (table_ready);
    limit = rows.size() + N_RANDOM + 50;
    #(limit * 20);
    $display("Watchdog expired, the run did not finish within %0d cycles", limit);
    end_failed();
  end

endmodule

//--- src.f
+incdir+design
design/rv_core_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_writeback.sv
design/rv_core_top.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the RV32I datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module rv_core_tb -o rv_core_sim

./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
